//--- all.f
+incdir+include
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/execUnit.sv
verilog/pcUnit.sv
verilog/singleCycleMips.sv
verif/tbSingleCycleMips.sv

//--- include/mipsCore_defs.svh
`ifndef MIPS_CORE_DEFS_SVH
`define MIPS_CORE_DEFS_SVH

// ==============================
// core sizing
// ==============================

// data word and instruction word width
`define MIPS_DATA_W 32

// register index width, 32 registers
`define MIPS_REG_AW 5

// data memory word address, taken from alu result bits 8 to 2
`define MIPS_DMEM_AW 7

// pc value held during and after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- run.sh
#!/bin/sh
# build and run the single-cycle core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tbSingleCycleMips -o simTb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "simulation log holds no result"
  exit 1
fi
exit 0

//--- verif/mipsProgram_golden.txt
# I byteAddr instrWord | D wordAddr dataWord | W regIdx writeData | S wordAddr storeData
# all values hex, W and S lines in program order
D 00 00000015
D 01 0000000c
D 02 fffffff0
D 03 12345678
I 00 8c010000
I 04 8c020004
I 08 8c030008
I 0c 00222020
I 10 00222822
I 14 00223024
I 18 00223825
I 1c 0061402a
I 20 0023482a
I 24 00415022
I 28 ac040010
I 2c 8c0b0010
I 30 ac4a000c
I 34 ac470200
I 38 8c0c000c
I 3c 108b0001
I 40 00216820
I 44 10220001
I 48 00227020
I 4c 0c000018
I 50 00217820
I 54 0800001c
I 58 00228020
I 5c 00000000
I 60 00238825
I 64 03e00008
I 68 00219020
I 6c 00000000
I 70 00220020
I 74 00029820
I 78 ac1f001c
I 7c 0800001f
W 01 00000015
W 02 0000000c
W 03 fffffff0
W 04 00000021
W 05 00000009
W 06 00000004
W 07 0000001d
W 08 00000001
W 09 00000000
W 0a fffffff7
W 0b 00000021
W 0c 0000001d
W 0e 00000021
W 1f 00000054
W 11 fffffff5
W 00 00000021
W 13 0000000c
S 04 00000021
S 06 fffffff7
S 03 0000001d
S 07 00000054

//--- verif/tbSingleCycleMips.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defs.svh"

module tbSingleCycleMips;

  // ==============================
  // dut connections
  // ==============================
  logic                      clk;
  logic                      rst;
  isaPkg::instrWord          instr;
  isaPkg::dataWord           memRData;
  isaPkg::dataWord           instrAddr;
  logic                      memCen;
  logic                      memWen;
  logic [`MIPS_DMEM_AW-1:0]  memAddr;
  isaPkg::dataWord           memWData;
  logic                      rfWriteEn;
  isaPkg::regIdx             rfWriteAddr;
  isaPkg::dataWord           rfWriteData;

  // instruction memory by byte address bits 9 to 2, data memory by word address
  isaPkg::dataWord imem [256];
  isaPkg::dataWord dmem [2 ** `MIPS_DMEM_AW];

  // expected events in program order
  isaPkg::regIdx            wbIdxQ [$];
  isaPkg::dataWord          wbDataQ [$];
  logic [`MIPS_DMEM_AW-1:0] stAddrQ [$];
  isaPkg::dataWord          stDataQ [$];

  integer seed;
  int     progLen = 0;
  longint watchLimit = 0;
  logic   running = 1'b0;
  // store seen at the falling edge, applied at the next rising edge
  logic                     storePending = 1'b0;
  logic [`MIPS_DMEM_AW-1:0] storeAddr = '0;
  isaPkg::dataWord          storeData = '0;
  int resetChecks = 0;
  int resetErrs = 0;
  int wbChecks = 0;
  int wbErrs = 0;
  int stChecks = 0;
  int stErrs = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  singleCycleMips dut0 (
    .clk(clk), .rst(rst), .instr(instr), .memRData(memRData), .instrAddr(instrAddr),
    .memCen(memCen), .memWen(memWen), .memAddr(memAddr), .memWData(memWData),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData)
  );

  always #4 clk = ~clk;

  // ==============================
  // memory models
  // ==============================
  // both answer in the same cycle
  assign instr    = imem[instrAddr[9:2]];
  assign memRData = memCen ? '0 : dmem[memAddr];

  always @(negedge clk) begin
    storePending <= rst && !memCen && !memWen;
    storeAddr    <= memAddr;
    storeData    <= memWData;
  end

  always @(posedge clk) begin
    if (storePending) begin
      dmem[storeAddr] <= storeData;
    end
  end

  // ==============================
  // golden file
  // ==============================
  task automatic loadGolden(output logic ok);
    integer fd;
    integer n;
    logic badLine;
    logic [7:0] tag;
    logic [31:0] a;
    logic [31:0] v;
    logic [8*160-1:0] rest;
    ok = 1'b0;
    badLine = 1'b0;
    fd = $fopen("verif/mipsProgram_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tag);
        if (n == 1 && tag == "#") begin
          // comment line
          n = $fgets(rest, fd);
        end else if (n == 1) begin
          n = $fscanf(fd, "%h %h", a, v);
          if (n != 2) begin
            $display("golden file has a line with tag %c that lacks two values", tag);
            badLine = 1'b1;
          end else begin
            case (tag)
              "I": begin
                imem[a[9:2]] = v;
                progLen++;
              end
              "D": dmem[a[`MIPS_DMEM_AW-1:0]] = v;
              "W": begin
                wbIdxQ.push_back(isaPkg::regIdx'(a));
                wbDataQ.push_back(v);
              end
              "S": begin
                stAddrQ.push_back(a[`MIPS_DMEM_AW-1:0]);
                stDataQ.push_back(v);
              end
              default: begin
                $display("golden file has an unknown tag %c", tag);
                badLine = 1'b1;
              end
            endcase
          end
        end
      end
      $fclose(fd);
      ok = (progLen > 0) && !badLine;
    end
  endtask

  // ==============================
  // compare tasks
  // ==============================
  task automatic checkResetState(input isaPkg::dataWord pc, input logic cen,
                                 input logic wen, input logic wbEn);
    resetChecks++;
    if (pc !== `MIPS_RESET_PC) begin
      $display("error t=%0t instrAddr expected %h got %h", $time, `MIPS_RESET_PC, pc);
      resetErrs++;
    end
    if (cen !== 1'b1 || wen !== 1'b1) begin
      $display("error t=%0t memCen/memWen expected 1/1 got %b/%b", $time, cen, wen);
      resetErrs++;
    end
    if (wbEn !== 1'b0) begin
      $display("error t=%0t rfWriteEn expected 0 got %b", $time, wbEn);
      resetErrs++;
    end
  endtask

  task automatic checkWriteback(input isaPkg::regIdx idx, input isaPkg::dataWord data);
    isaPkg::regIdx   expIdx;
    isaPkg::dataWord expData;
    if (wbIdxQ.size() == 0) begin
      $display("write-back to r%0d at %0t ns was not expected by the golden file", idx, $time);
      wbErrs++;
    end else begin
      expIdx  = wbIdxQ.pop_front();
      expData = wbDataQ.pop_front();
      wbChecks++;
      if (idx !== expIdx) begin
        $display("error t=%0t rfWriteAddr expected %0d got %0d", $time, expIdx, idx);
        wbErrs++;
      end
      if (data !== expData) begin
        $display("error t=%0t rfWriteData expected %h got %h", $time, expData, data);
        wbErrs++;
      end
    end
  endtask

  task automatic checkStore(input logic [`MIPS_DMEM_AW-1:0] addr, input isaPkg::dataWord data);
    logic [`MIPS_DMEM_AW-1:0] expAddr;
    isaPkg::dataWord          expData;
    if (stAddrQ.size() == 0) begin
      $display("store to word %0d at %0t ns was not expected by the golden file", addr, $time);
      stErrs++;
    end else begin
      expAddr = stAddrQ.pop_front();
      expData = stDataQ.pop_front();
      stChecks++;
      if (addr !== expAddr) begin
        $display("error t=%0t memAddr expected %h got %h", $time, expAddr, addr);
        stErrs++;
      end
      if (data !== expData) begin
        $display("error t=%0t memWData expected %h got %h", $time, expData, data);
        stErrs++;
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      checkResetState(instrAddr, memCen, memWen, rfWriteEn);
    end else if (running) begin
      if (rfWriteEn) begin
        checkWriteback(rfWriteAddr, rfWriteData);
      end
      if (!memCen && !memWen) begin
        checkStore(memAddr, memWData);
      end
    end
  end

  // end of program is a j to its own address
  function automatic logic isSelfJump(input isaPkg::instrWord iw, input isaPkg::dataWord pc);
    isaPkg::dataWord pcPlus4;
    pcPlus4 = pc + 32'd4;
    return (iw.j.op == isaPkg::opJ) && ({pcPlus4[31:28], iw.j.target, 2'b00} == pc);
  endfunction

  task automatic reportTest(input string name, input int checks, input int errs);
    if (errs == 0) begin
      testsPassed++;
      $display("test %s: passed, %0d checks", name, checks);
    end else begin
      testsFailed++;
      $display("test %s: failed, %0d errors in %0d checks", name, errs, checks);
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin : mainFlow
    logic loaded;
    logic halted;
    int   wbMissing;
    int   stMissing;
    clk       = 1'b0;
    rst       = 1'b0;
    halted    = 1'b0;
    wbMissing = 0;
    stMissing = 0;
    seed      = 78687;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    // words not preset by the golden file get random contents
    for (int i = 0; i < 2 ** `MIPS_DMEM_AW; i++) begin
      dmem[i] = $random(seed);
    end
    loadGolden(loaded);
    if (loaded) begin
      watchLimit = longint'(16 + 4 * progLen) * 8;
    end
    repeat (16) @(posedge clk);
    #1;
    rst     = 1'b1;
    running = loaded;
    reportTest("reset", resetChecks, resetErrs);
    if (loaded) begin
      while (!halted) begin
        @(negedge clk);
        halted = isSelfJump(instr, instrAddr);
      end
      // let the checkers finish the last cycle
      @(posedge clk);
      wbMissing = wbIdxQ.size();
      stMissing = stAddrQ.size();
      if (wbMissing != 0) begin
        $display("%0d expected write-backs never happened", wbMissing);
      end
      if (stMissing != 0) begin
        $display("%0d expected stores never happened", stMissing);
      end
    end else begin
      $display("golden file could not be read cleanly, so the program was not run");
      wbMissing = 1;
      stMissing = 1;
    end
    reportTest("writeback", wbChecks, wbErrs + wbMissing);
    reportTest("store", stChecks, stErrs + stMissing);
    $display("summary: %0d tests passed, %0d tests failed", testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog allows four cycles per program word on top of reset
  initial begin : watchdog
    wait (watchLimit != 0);
    #(watchLimit);
    $display("timeout: the program did not reach its final jump after %0d ns", watchLimit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // ==============================
  // alu operation select
  // ==============================
  // r-type picks from funct, lw/sw add, beq subtracts
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    // signed compare, result is 0 or 1
    aluSlt = 3'd4
  } aluOp;

  // ==============================
  // write-back source
  // ==============================
  typedef enum logic [1:0] {
    // r-type results
    wbAlu  = 2'd0,
    // lw data from the memory port
    wbMem  = 2'd1,
    // jal return address, pc plus 8
    wbLink = 2'd2
  } wbSrc;

endpackage

`default_nettype wire

//--- verilog/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defs.svh"

module execUnit (
  input  wire isaPkg::dataWord      rsData,
  input  wire isaPkg::dataWord      rtData,
  input  wire isaPkg::dataWord      immExt,
  input  wire ctrlPkg::aluOp        aluSel,
  input  wire                       aluSrcImm,
  input  wire                       memRead,
  input  wire                       memWrite,
  input  wire                       regWrite,
  input  wire ctrlPkg::wbSrc        wbSel,
  input  wire isaPkg::regIdx        destIdx,
  input  wire isaPkg::dataWord      memRData,
  input  wire isaPkg::dataWord      linkAddr,
  input  wire                       rst,
  output logic                      aluZero,
  output logic                      memCen,
  output logic                      memWen,
  output logic [`MIPS_DMEM_AW-1:0]  memAddr,
  output isaPkg::dataWord           memWData,
  output logic                      wbEn,
  output isaPkg::regIdx             wbIdx,
  output isaPkg::dataWord           wbData
);

  isaPkg::dataWord aluB;
  isaPkg::dataWord aluRes;

  // ==============================
  // alu
  // ==============================
  // immediate for lw/sw, rt otherwise
  assign aluB = aluSrcImm ? immExt : rtData;

  always_comb begin
    case (aluSel)
      ctrlPkg::aluAdd: aluRes = rsData + aluB;
      ctrlPkg::aluSub: aluRes = rsData - aluB;
      ctrlPkg::aluAnd: aluRes = rsData & aluB;
      ctrlPkg::aluOr:  aluRes = rsData | aluB;
      // signed compare, 1 or 0
      ctrlPkg::aluSlt: aluRes = {{(`MIPS_DATA_W-1){1'b0}}, $signed(rsData) < $signed(aluB)};
      default:         aluRes = '0;
    endcase
  end

  // beq uses this after a subtract
  assign aluZero = (aluRes == '0);

  // ==============================
  // data memory request
  // ==============================
  // both strobes active low, idle while in reset
  assign memCen   = ~(rst & (memRead | memWrite));
  assign memWen   = ~(rst & memWrite);
  // byte address to word address
  assign memAddr  = aluRes[`MIPS_DMEM_AW+1:2];
  // store data comes straight from rt
  assign memWData = rtData;

  // ==============================
  // write-back
  // ==============================
  assign wbEn  = rst & regWrite;
  assign wbIdx = destIdx;

  always_comb begin
    case (wbSel)
      ctrlPkg::wbMem:  wbData = memRData;
      // jal return address
      ctrlPkg::wbLink: wbData = linkAddr;
      default:         wbData = aluRes;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defs.svh"

module instrDecoder (
  input  wire isaPkg::instrWord instr,
  input  wire                   rst,
  output isaPkg::regIdx         rsIdx,
  output isaPkg::regIdx         rtIdx,
  output isaPkg::regIdx         rdIdx,
  output isaPkg::dataWord       immExt,
  output logic [25:0]           jumpTarget,
  output ctrlPkg::aluOp         aluSel,
  output logic                  aluSrcImm,
  output logic                  memRead,
  output logic                  memWrite,
  output logic                  regWrite,
  output ctrlPkg::wbSrc         wbSel,
  output logic                  destSel,
  output logic                  branch,
  output logic                  jump,
  output logic                  jumpReg
);

  // ==============================
  // field extraction
  // ==============================
  // rs and rt sit at the same bits in r and i format
  assign rsIdx      = instr.r.rs;
  assign rtIdx      = instr.r.rt;
  assign immExt     = {{(`MIPS_DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
  assign jumpTarget = instr.j.target;

  // ==============================
  // main and alu control in one table
  // ==============================
  always_comb begin
    // default is no write, no memory access and a sequential pc
    aluSel    = ctrlPkg::aluAdd;
    aluSrcImm = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    regWrite  = 1'b0;
    wbSel     = ctrlPkg::wbAlu;
    destSel   = 1'b0;
    rdIdx     = instr.i.rt;
    branch    = 1'b0;
    jump      = 1'b0;
    jumpReg   = 1'b0;
    case (instr.r.op)
      isaPkg::opR: begin
        // destination from the rd field
        destSel  = 1'b1;
        rdIdx    = instr.r.rd;
        regWrite = 1'b1;
        case (instr.r.fn)
          isaPkg::fnAdd: aluSel = ctrlPkg::aluAdd;
          isaPkg::fnSub: aluSel = ctrlPkg::aluSub;
          isaPkg::fnAnd: aluSel = ctrlPkg::aluAnd;
          isaPkg::fnOr:  aluSel = ctrlPkg::aluOr;
          isaPkg::fnSlt: aluSel = ctrlPkg::aluSlt;
          isaPkg::fnJr: begin
            // jump to rs and write nothing
            regWrite = 1'b0;
            jumpReg  = 1'b1;
          end
          // unknown funct acts as a nop
          default: regWrite = 1'b0;
        endcase
      end
      isaPkg::opLw: begin
        aluSrcImm = 1'b1;
        memRead   = 1'b1;
        regWrite  = 1'b1;
        wbSel     = ctrlPkg::wbMem;
      end
      isaPkg::opSw: begin
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
      end
      isaPkg::opBeq: begin
        // equal when rs minus rt is zero
        aluSel = ctrlPkg::aluSub;
        branch = 1'b1;
      end
      isaPkg::opJ: jump = 1'b1;
      isaPkg::opJal: begin
        jump     = 1'b1;
        regWrite = 1'b1;
        wbSel    = ctrlPkg::wbLink;
        rdIdx    = isaPkg::regIdx'(31);
      end
      // unknown opcode keeps the defaults
      default: ;
    endcase
    // in reset the core must not touch state
    if (!rst) begin
      memRead  = 1'b0;
      memWrite = 1'b0;
      regWrite = 1'b0;
      branch   = 1'b0;
      jump     = 1'b0;
      jumpReg  = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none

`include "mipsCore_defs.svh"

package isaPkg;

  // basic word types
  typedef logic [`MIPS_DATA_W-1:0] dataWord;
  typedef logic [`MIPS_REG_AW-1:0] regIdx;

  // primary opcode field, bits 31 to 26
  typedef enum logic [5:0] {
    opR   = 6'h00,
    opJ   = 6'h02,
    opJal = 6'h03,
    opBeq = 6'h04,
    opLw  = 6'h23,
    opSw  = 6'h2b
  } opcode;

  // r-format function field, bits 5 to 0
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } funct;

  // ==============================
  // one instruction word, three formats
  // ==============================
  typedef union packed {
    struct packed {
      opcode         op;
      regIdx         rs;
      regIdx         rt;
      regIdx         rd;
      logic [4:0]    shamt;
      funct          fn;
    } r;
    struct packed {
      opcode         op;
      regIdx         rs;
      regIdx         rt;
      logic [15:0]   imm;
    } i;
    struct packed {
      opcode         op;
      logic [25:0]   target;
    } j;
  } instrWord;

endpackage

`default_nettype wire

//--- verilog/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defs.svh"

module pcUnit (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  branch,
  input  wire                  jump,
  input  wire                  jumpReg,
  input  wire                  aluZero,
  input  wire isaPkg::dataWord immExt,
  input  wire [25:0]           jumpTarget,
  input  wire isaPkg::dataWord rsData,
  output isaPkg::dataWord      pc,
  output isaPkg::dataWord      linkAddr
);

  isaPkg::dataWord pcPlus4;
  isaPkg::dataWord branchAddr;
  isaPkg::dataWord jumpAddr;
  isaPkg::dataWord pcNext;

  // ==============================
  // candidate targets
  // ==============================
  assign pcPlus4    = pc + isaPkg::dataWord'(4);
  // return address skips the slot after jal
  assign linkAddr   = pc + isaPkg::dataWord'(8);
  // word offset relative to pc plus 4
  assign branchAddr = pcPlus4 + {immExt[`MIPS_DATA_W-3:0], 2'b00};
  // keep the upper region bits of pc plus 4
  assign jumpAddr   = {pcPlus4[`MIPS_DATA_W-1:28], jumpTarget, 2'b00};

  // priority: jr, then j/jal, then taken beq
  always_comb begin
    if (jumpReg) begin
      pcNext = rsData;
    end else if (jump) begin
      pcNext = jumpAddr;
    end else if (branch && aluZero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defs.svh"

module registerFile (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  writeEn,
  input  wire isaPkg::regIdx   writeIdx,
  input  wire isaPkg::dataWord writeData,
  input  wire isaPkg::regIdx   rsIdx,
  input  wire isaPkg::regIdx   rtIdx,
  output isaPkg::dataWord      rsData,
  output isaPkg::dataWord      rtData
);

  localparam int numRegs = 2 ** `MIPS_REG_AW;

  // general purpose registers
  isaPkg::dataWord regs [numRegs];

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // all registers start at zero
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeIdx != '0)) begin
      // r0 is never written
      regs[writeIdx] <= writeData;
    end
  end

  // ==============================
  // read ports, combinational
  // ==============================
  // r0 reads as zero
  assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
  assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

`default_nettype wire

//--- verilog/singleCycleMips.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defs.svh"

module singleCycleMips (
  input  wire                       clk,
  input  wire                       rst,
  input  wire isaPkg::instrWord     instr,
  input  wire isaPkg::dataWord      memRData,
  output isaPkg::dataWord           instrAddr,
  output logic                      memCen,
  output logic                      memWen,
  output logic [`MIPS_DMEM_AW-1:0]  memAddr,
  output isaPkg::dataWord           memWData,
  output logic                      rfWriteEn,
  output isaPkg::regIdx             rfWriteAddr,
  output isaPkg::dataWord           rfWriteData
);

  // ==============================
  // decoder outputs
  // ==============================
  isaPkg::regIdx   rsIdx;
  isaPkg::regIdx   rtIdx;
  isaPkg::regIdx   rdIdx;
  isaPkg::dataWord immExt;
  logic [25:0]     jumpTarget;
  ctrlPkg::aluOp   aluSel;
  logic            aluSrcImm;
  logic            memRead;
  logic            memWrite;
  logic            regWrite;
  ctrlPkg::wbSrc   wbSel;
  logic            branch;
  logic            jump;
  logic            jumpReg;

  // register reads, alu flag, link value
  isaPkg::dataWord rsData;
  isaPkg::dataWord rtData;
  logic            aluZero;
  isaPkg::dataWord linkAddr;

  instrDecoder dec0 (
    .instr(instr), .rst(rst), .rsIdx(rsIdx), .rtIdx(rtIdx), .rdIdx(rdIdx),
    .immExt(immExt), .jumpTarget(jumpTarget), .aluSel(aluSel), .aluSrcImm(aluSrcImm),
    .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite), .wbSel(wbSel),
    .destSel(), .branch(branch), .jump(jump), .jumpReg(jumpReg)
  );

  // write port fed back from the write-back stage
  registerFile rf0 (
    .clk(clk), .rst(rst), .writeEn(rfWriteEn), .writeIdx(rfWriteAddr),
    .writeData(rfWriteData), .rsIdx(rsIdx), .rtIdx(rtIdx), .rsData(rsData), .rtData(rtData)
  );

  execUnit ex0 (
    .rsData(rsData), .rtData(rtData), .immExt(immExt), .aluSel(aluSel),
    .aluSrcImm(aluSrcImm), .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
    .wbSel(wbSel), .destIdx(rdIdx), .memRData(memRData), .linkAddr(linkAddr), .rst(rst),
    .aluZero(aluZero), .memCen(memCen), .memWen(memWen), .memAddr(memAddr),
    .memWData(memWData), .wbEn(rfWriteEn), .wbIdx(rfWriteAddr), .wbData(rfWriteData)
  );

  // pc drives the instruction port directly
  pcUnit pc0 (
    .clk(clk), .rst(rst), .branch(branch), .jump(jump), .jumpReg(jumpReg),
    .aluZero(aluZero), .immExt(immExt), .jumpTarget(jumpTarget), .rsData(rsData),
    .pc(instrAddr), .linkAddr(linkAddr)
  );

endmodule

`default_nettype wire
